/* cpuMacros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define XLEN 32

// architectural register count
`define NREGS 32

// register index width
`define REGW 5

`endif

/* isaPkg.sv */
`include "cpuMacros.svh"

package isaPkg;

	// RV32I major opcodes in use
	typedef enum logic [6:0] {
		op     = 7'b0110011,
		opImm  = 7'b0010011,
		load   = 7'b0000011,
		store  = 7'b0100011,
		branch = 7'b1100011,
		jal    = 7'b1101111
	} opcode_t;

	// command class seen by the hazard logic
	typedef enum logic [1:0] {
		other  = 2'b00,
		jmpCmd = 2'b01,
		stCmd  = 2'b10,
		lwCmd  = 2'b11
	} cmd_t;

	typedef enum logic [1:0] {
		add,
		sub,
		andOp,
		orOp
	} aluOp_t;

	// funct fields of the supported subset
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;
	localparam logic [2:0] f3Word   = 3'b010;
	localparam logic [2:0] f3Beq    = 3'b000;
	localparam logic [6:0] f7Base   = 7'b0000000;
	localparam logic [6:0] f7Sub    = 7'b0100000;

	typedef struct packed {
		cmd_t              cmd;
		aluOp_t            aluOp;
		logic [`REGW-1:0]  rs1;
		logic [`REGW-1:0]  rs2;
		logic [`REGW-1:0]  rd;
		logic              weReg;
		logic              useImm;
		logic              isBranch;
		logic [`XLEN-1:0]  imm;
	} decoded_t;

endpackage

/* pipePkg.sv */
`include "cpuMacros.svh"

package pipePkg;

	// operand source in execute
	typedef enum logic [1:0] {
		fwdNone = 2'b00,
		fwdMem  = 2'b01,
		fwdWb   = 2'b10
	} fwdSel_t;

	typedef struct packed {
		logic              valid;
		logic [`XLEN-1:0]  pc;
		isaPkg::decoded_t  dec;
		logic [`XLEN-1:0]  rs1Val;
		logic [`XLEN-1:0]  rs2Val;
	} decExe_t;

	typedef struct packed {
		logic              valid;
		isaPkg::cmd_t      cmd;
		logic [`REGW-1:0]  rd;
		logic              weReg;
		logic [`XLEN-1:0]  result;
		logic [`XLEN-1:0]  storeData;
	} exeMem_t;

	typedef struct packed {
		logic              valid;
		logic [`REGW-1:0]  rd;
		logic              weReg;
		logic [`XLEN-1:0]  result;
	} memWb_t;

endpackage

/* hazardIf.sv */
`include "cpuMacros.svh"

interface hazardIf;

	// stage state observed by the hazard unit
	logic [`REGW-1:0]    rs1D;
	logic [`REGW-1:0]    rs2D;
	logic [`REGW-1:0]    rs1E;
	logic [`REGW-1:0]    rs2E;
	logic [`REGW-1:0]    rdE;
	isaPkg::cmd_t        cmdE;
	logic [`REGW-1:0]    rdM;
	logic                weM;
	logic [`REGW-1:0]    rdW;
	logic                weW;
	logic                redirectE;

	// pipeline controls
	logic                stallF;
	logic                stallD;
	logic                flushD;
	logic                flushE;
	pipePkg::fwdSel_t    fwdA;
	pipePkg::fwdSel_t    fwdB;

	modport pipe (
		output rs1D, rs2D, rs1E, rs2E, rdE, cmdE, rdM, weM, rdW, weW, redirectE,
		input  stallF, stallD, flushD, flushE, fwdA, fwdB
	);

	modport hazard (
		input  rs1D, rs2D, rs1E, rs2E, rdE, cmdE, rdM, weM, rdW, weW, redirectE,
		output stallF, stallD, flushD, flushE, fwdA, fwdB
	);

endinterface

/* hazardUnit.sv */
`include "cpuMacros.svh"

module hazardUnit (
	hazardIf.hazard hz
);

	logic loadUse;
	logic rdEMatch;

	// pick the youngest producer of a source register
	function automatic pipePkg::fwdSel_t fwdPick(
		input logic [`REGW-1:0] rs,
		input logic [`REGW-1:0] rdM,
		input logic             weM,
		input logic [`REGW-1:0] rdW,
		input logic             weW
	);
		pipePkg::fwdSel_t sel;
		sel = pipePkg::fwdNone;
		if (rs != '0) begin
			if (weM && rs == rdM) begin
				sel = pipePkg::fwdMem;
			end else if (weW && rs == rdW) begin
				sel = pipePkg::fwdWb;
			end
		end
		return sel;
	endfunction

	assign rdEMatch = (hz.rdE == hz.rs1D) || (hz.rdE == hz.rs2D);

	// load in execute feeding the instruction in decode
	assign loadUse = (hz.cmdE == isaPkg::lwCmd) && (hz.rdE != '0) && rdEMatch;

	always_comb begin
		hz.stallF = 1'b0;
		hz.stallD = 1'b0;
		hz.flushD = 1'b0;
		hz.flushE = 1'b0;

		if (hz.redirectE) begin
			// wrong-path instructions in fetch/decode are dropped
			hz.flushD = 1'b1;
			hz.flushE = 1'b1;
		end else if (loadUse) begin
			hz.stallF = 1'b1;
			hz.stallD = 1'b1;
			// bubble into execute
			hz.flushE = 1'b1;
		end
	end

	always_comb begin
		hz.fwdA = fwdPick(hz.rs1E, hz.rdM, hz.weM, hz.rdW, hz.weW);
		hz.fwdB = fwdPick(hz.rs2E, hz.rdM, hz.weM, hz.rdW, hz.weW);
	end

endmodule

/* regFile.sv */
`include "cpuMacros.svh"

module regFile (
	input  logic              clk,
	input  logic              reset,
	input  logic [`REGW-1:0]  rs1,
	input  logic [`REGW-1:0]  rs2,
	output logic [`XLEN-1:0]  rd1,
	output logic [`XLEN-1:0]  rd2,
	input  logic              we,
	input  logic [`REGW-1:0]  wAddr,
	input  logic [`XLEN-1:0]  wData
);

	logic [`XLEN-1:0] regs [`NREGS];
	logic             wrLive;

	// x0 never takes a write
	assign wrLive = we && (wAddr != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wAddr] <= wData;
		end
	end

	// same-cycle writeback shows through on reads
	assign rd1 = (wrLive && wAddr == rs1) ? wData : regs[rs1];
	assign rd2 = (wrLive && wAddr == rs2) ? wData : regs[rs2];

endmodule

/* pipeReg.sv */
module pipeReg #(
	parameter type payload_t = logic
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      enable,
	input  logic      flush,
	input  payload_t  d,
	output payload_t  q
);

	// an all-zero payload is a bubble
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end

endmodule

/* decoder.sv */
`include "cpuMacros.svh"

module decoder (
	input  logic [`XLEN-1:0]  instr,
	output isaPkg::decoded_t  dec
);

	logic [2:0]        f3;
	logic [6:0]        f7;
	logic [`XLEN-1:0]  immI;
	logic [`XLEN-1:0]  immS;
	logic [`XLEN-1:0]  immB;
	logic [`XLEN-1:0]  immJ;

	assign f3 = instr[14:12];
	assign f7 = instr[31:25];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// unused source fields stay at x0 so they never trigger a stall
	always_comb begin
		dec = '0;
		case (instr[6:0])
			isaPkg::op: begin
				if (f3 == isaPkg::f3AddSub && (f7 == isaPkg::f7Base || f7 == isaPkg::f7Sub)) begin
					dec.aluOp = (f7 == isaPkg::f7Sub) ? isaPkg::sub : isaPkg::add;
					dec.weReg = 1'b1;
				end else if (f3 == isaPkg::f3And && f7 == isaPkg::f7Base) begin
					dec.aluOp = isaPkg::andOp;
					dec.weReg = 1'b1;
				end else if (f3 == isaPkg::f3Or && f7 == isaPkg::f7Base) begin
					dec.aluOp = isaPkg::orOp;
					dec.weReg = 1'b1;
				end
				if (dec.weReg) begin
					dec.rs1 = instr[19:15];
					dec.rs2 = instr[24:20];
					dec.rd = instr[11:7];
				end
			end
			isaPkg::opImm, isaPkg::load: begin
				if (f3 == ((instr[6:0] == isaPkg::load) ? isaPkg::f3Word : isaPkg::f3AddSub)) begin
					dec.cmd = (instr[6:0] == isaPkg::load) ? isaPkg::lwCmd : isaPkg::other;
					dec.rs1 = instr[19:15];
					dec.rd = instr[11:7];
					dec.weReg = 1'b1;
					dec.useImm = 1'b1;
					dec.imm = immI;
				end
			end
			isaPkg::store: begin
				if (f3 == isaPkg::f3Word) begin
					dec.cmd = isaPkg::stCmd;
					dec.rs1 = instr[19:15];
					dec.rs2 = instr[24:20];
					dec.useImm = 1'b1;
					dec.imm = immS;
				end
			end
			isaPkg::branch: begin
				if (f3 == isaPkg::f3Beq) begin
					dec.rs1 = instr[19:15];
					dec.rs2 = instr[24:20];
					dec.isBranch = 1'b1;
					dec.imm = immB;
				end
			end
			isaPkg::jal: begin
				dec.cmd = isaPkg::jmpCmd;
				dec.rd = instr[11:7];
				dec.weReg = 1'b1;
				dec.imm = immJ;
			end
			default: dec = '0;
		endcase
	end

endmodule

/* execUnit.sv */
`include "cpuMacros.svh"

module execUnit (
	input  pipePkg::decExe_t  payload,
	input  pipePkg::fwdSel_t  fwdA,
	input  pipePkg::fwdSel_t  fwdB,
	input  logic [`XLEN-1:0]  memResult,
	input  logic [`XLEN-1:0]  wbResult,
	output logic [`XLEN-1:0]  result,
	output logic [`XLEN-1:0]  storeData,
	output logic              redirect,
	output logic [`XLEN-1:0]  target
);

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] regB;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluOut;

	function automatic logic [`XLEN-1:0] fwdMux(
		input pipePkg::fwdSel_t sel,
		input logic [`XLEN-1:0] regVal,
		input logic [`XLEN-1:0] memVal,
		input logic [`XLEN-1:0] wbVal
	);
		case (sel)
			pipePkg::fwdMem: return memVal;
			pipePkg::fwdWb:  return wbVal;
			default:         return regVal;
		endcase
	endfunction

	assign opA = fwdMux(fwdA, payload.rs1Val, memResult, wbResult);
	assign regB = fwdMux(fwdB, payload.rs2Val, memResult, wbResult);
	assign opB = payload.dec.useImm ? payload.dec.imm : regB;

	always_comb begin
		case (payload.dec.aluOp)
			isaPkg::sub:   aluOut = opA - opB;
			isaPkg::andOp: aluOut = opA & opB;
			isaPkg::orOp:  aluOut = opA | opB;
			default:       aluOut = opA + opB;
		endcase
	end

	// jal links pc+4
	assign result = (payload.dec.cmd == isaPkg::jmpCmd) ? payload.pc + `XLEN'd4 : aluOut;
	assign storeData = regB;

	assign redirect = payload.valid &&
		((payload.dec.cmd == isaPkg::jmpCmd) || (payload.dec.isBranch && opA == regB));
	assign target = payload.pc + payload.dec.imm;

endmodule

/* pipelineCore.sv */
`include "cpuMacros.svh"

module pipelineCore (
	input  logic              clk,
	input  logic              reset,
	output logic [`XLEN-1:0]  imemAddr,
	input  logic [`XLEN-1:0]  imemData,
	output logic [`XLEN-1:0]  dmemAddr,
	output logic [`XLEN-1:0]  dmemWdata,
	output logic              dmemWe,
	input  logic [`XLEN-1:0]  dmemRdata,
	output logic              wbValid,
	output logic [`REGW-1:0]  wbRd,
	output logic [`XLEN-1:0]  wbData
);

	typedef struct packed {
		logic              valid;
		logic [`XLEN-1:0]  pc;
		logic [`XLEN-1:0]  instr;
	} fetchDec_t;

	logic [`XLEN-1:0]   pc;
	fetchDec_t          fdD;
	fetchDec_t          fdQ;
	isaPkg::decoded_t   decoded;
	logic [`XLEN-1:0]   rd1;
	logic [`XLEN-1:0]   rd2;
	pipePkg::decExe_t   deD;
	pipePkg::decExe_t   deQ;
	pipePkg::exeMem_t   emD;
	pipePkg::exeMem_t   emQ;
	pipePkg::memWb_t    mwD;
	pipePkg::memWb_t    mwQ;
	logic [`XLEN-1:0]   exeResult;
	logic [`XLEN-1:0]   exeStoreData;
	logic               redirect;
	logic [`XLEN-1:0]   target;
	logic [`XLEN-1:0]   memResult;
	logic               weW;

	hazardIf hz ();

	hazardUnit u_hazardUnit (.hz(hz.hazard));

	// fetch
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= target;
		end else if (!hz.stallF) begin
			pc <= pc + `XLEN'd4;
		end
	end

	assign imemAddr = pc;
	assign fdD = '{valid: 1'b1, pc: pc, instr: imemData};

	pipeReg #(.payload_t(fetchDec_t)) u_fetchDec (
		.clk(clk), .reset(reset), .enable(!hz.stallD), .flush(hz.flushD), .d(fdD), .q(fdQ)
	);

	// decode
	decoder u_decoder (.instr(fdQ.instr), .dec(decoded));

	regFile u_regFile (
		.clk(clk), .reset(reset), .rs1(decoded.rs1), .rs2(decoded.rs2),
		.rd1(rd1), .rd2(rd2), .we(weW), .wAddr(mwQ.rd), .wData(mwQ.result)
	);

	assign deD = '{valid: fdQ.valid, pc: fdQ.pc, dec: decoded, rs1Val: rd1, rs2Val: rd2};

	pipeReg #(.payload_t(pipePkg::decExe_t)) u_decExe (
		.clk(clk), .reset(reset), .enable(1'b1), .flush(hz.flushE), .d(deD), .q(deQ)
	);

	// execute
	execUnit u_execUnit (
		.payload(deQ), .fwdA(hz.fwdA), .fwdB(hz.fwdB),
		.memResult(memResult), .wbResult(mwQ.result),
		.result(exeResult), .storeData(exeStoreData), .redirect(redirect), .target(target)
	);

	assign emD = '{
		valid: deQ.valid,
		cmd: deQ.dec.cmd,
		rd: deQ.dec.rd,
		weReg: deQ.dec.weReg,
		result: exeResult,
		storeData: exeStoreData
	};

	pipeReg #(.payload_t(pipePkg::exeMem_t)) u_exeMem (
		.clk(clk), .reset(reset), .enable(1'b1), .flush(1'b0), .d(emD), .q(emQ)
	);

	// memory
	assign dmemAddr = emQ.result;
	assign dmemWdata = emQ.storeData;
	assign dmemWe = emQ.valid && (emQ.cmd == isaPkg::stCmd);
	assign memResult = (emQ.cmd == isaPkg::lwCmd) ? dmemRdata : emQ.result;

	assign mwD = '{valid: emQ.valid, rd: emQ.rd, weReg: emQ.weReg, result: memResult};

	pipeReg #(.payload_t(pipePkg::memWb_t)) u_memWb (
		.clk(clk), .reset(reset), .enable(1'b1), .flush(1'b0), .d(mwD), .q(mwQ)
	);

	// writeback
	assign weW = mwQ.valid && mwQ.weReg;
	assign wbValid = weW && (mwQ.rd != '0);
	assign wbRd = mwQ.rd;
	assign wbData = mwQ.result;

	// hazard unit view of the stages
	assign hz.rs1D = decoded.rs1;
	assign hz.rs2D = decoded.rs2;
	assign hz.rs1E = deQ.dec.rs1;
	assign hz.rs2E = deQ.dec.rs2;
	assign hz.rdE = deQ.dec.rd;
	assign hz.cmdE = deQ.dec.cmd;
	assign hz.rdM = emQ.rd;
	assign hz.weM = emQ.valid && emQ.weReg;
	assign hz.rdW = mwQ.rd;
	assign hz.weW = weW;
	assign hz.redirectE = redirect;

endmodule

/* tbCore.sv */
`include "cpuMacros.svh"

module tbCore;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int pulseTimeout = 100;
	localparam int runTimeout = 5000;
	localparam int modelStepLimit = 10000;

	typedef enum int {
		insAdd,
		insSub,
		insAnd,
		insOr,
		insAddi,
		insLw,
		insSw,
		insBeq,
		insJal
	} insKind_t;

	typedef struct packed {
		logic [`REGW-1:0]  rd;
		logic [`XLEN-1:0]  value;
	} write_t;

	typedef struct packed {
		logic [`XLEN-1:0]  addr;
		logic [`XLEN-1:0]  data;
	} store_t;

	logic              clk;
	logic              reset = 1'b1;
	logic [`XLEN-1:0]  imemAddr;
	logic [`XLEN-1:0]  imemData = '0;
	logic [`XLEN-1:0]  dmemAddr;
	logic [`XLEN-1:0]  dmemWdata;
	logic              dmemWe;
	logic [`XLEN-1:0]  dmemRdata = '0;
	logic              wbValid;
	logic [`REGW-1:0]  wbRd;
	logic [`XLEN-1:0]  wbData;

	logic [`XLEN-1:0]  imem [512];
	logic [`XLEN-1:0]  dmem [256];

	// program fields before assembly into imem
	insKind_t          progKind [$];
	logic [`REGW-1:0]  progRd [$];
	logic [`REGW-1:0]  progRs1 [$];
	logic [`REGW-1:0]  progRs2 [$];
	int                progImm [$];

	write_t            writeQ [$];
	store_t            storeQ [$];
	write_t            expWrite;
	store_t            expStore;
	int                idleCycles = 0;
	int                resetCycles = 0;

	pipelineCore u_pipelineCore (
		.clk(clk), .reset(reset), .imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe), .dmemRdata(dmemRdata),
		.wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic void endOnFailure();
		$display("TEST FAIL");
		$fatal(1, "run stopped after the first failure");
	endfunction

	function automatic void failRun(input string msg);
		$display("%s", msg);
		endOnFailure();
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%08h expected 0x%08h", name, got, exp);
			endOnFailure();
		end
	endtask

	// initial data memory contents that differ per word
	function automatic logic [`XLEN-1:0] fillWord(input int idx);
		logic [7:0] a;
		a = idx[7:0];
		return {a, ~a, a ^ 8'h5A, 8'hC3};
	endfunction

	function automatic void clearProgram();
		progKind.delete();
		progRd.delete();
		progRs1.delete();
		progRs2.delete();
		progImm.delete();
	endfunction

	function automatic void addIns(insKind_t kind, int rd, int rs1, int rs2, int imm);
		progKind.push_back(kind);
		progRd.push_back(`REGW'(rd));
		progRs1.push_back(`REGW'(rs1));
		progRs2.push_back(`REGW'(rs2));
		progImm.push_back(imm);
	endfunction

	// RV32I encodings
	function automatic logic [`XLEN-1:0] encode(input int idx);
		logic [`XLEN-1:0]  im;
		logic [`REGW-1:0]  rd;
		logic [`REGW-1:0]  rs1;
		logic [`REGW-1:0]  rs2;
		im = progImm[idx];
		rd = progRd[idx];
		rs1 = progRs1[idx];
		rs2 = progRs2[idx];
		case (progKind[idx])
			insAdd:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			insSub:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
			insAnd:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
			insOr:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
			insAddi: return {im[11:0], rs1, 3'b000, rd, 7'b0010011};
			insLw:   return {im[11:0], rs1, 3'b010, rd, 7'b0000011};
			insSw:   return {im[11:5], rs2, rs1, 3'b010, im[4:0], 7'b0100011};
			insBeq:  return {im[12], im[10:5], rs2, rs1, 3'b000, im[4:1], im[11], 7'b1100011};
			default: return {im[20], im[10:1], im[11], im[19:12], rd, 7'b1101111};
		endcase
	endfunction

	// architectural model that fills the expected write and store lists
	function automatic void runReference();
		logic [`XLEN-1:0]  regs [`NREGS];
		logic [`XLEN-1:0]  mem [256];
		logic [`XLEN-1:0]  a;
		logic [`XLEN-1:0]  b;
		logic [`XLEN-1:0]  imm;
		logic [`XLEN-1:0]  addr;
		logic [`XLEN-1:0]  val;
		logic              writes;
		int                pc;
		int                nextPc;
		int                steps;
		bit                halted;
		regs = '{default: '0};
		for (int i = 0; i < 256; i++) begin
			mem[i[7:0]] = fillWord(i);
		end
		writeQ.delete();
		storeQ.delete();
		pc = 0;
		steps = 0;
		halted = 1'b0;
		while (!halted && steps < modelStepLimit && pc >= 0 && pc < progKind.size()) begin
			if (progKind[pc] == insJal && progImm[pc] == 0) begin
				halted = 1'b1;
			end else begin
				a = regs[progRs1[pc]];
				b = regs[progRs2[pc]];
				imm = progImm[pc];
				addr = a + imm;
				val = '0;
				writes = 1'b1;
				nextPc = pc + 1;
				case (progKind[pc])
					insAdd:  val = a + b;
					insSub:  val = a - b;
					insAnd:  val = a & b;
					insOr:   val = a | b;
					insAddi: val = a + imm;
					insLw:   val = mem[addr[9:2]];
					insSw: begin
						writes = 1'b0;
						mem[addr[9:2]] = b;
						storeQ.push_back('{addr: addr, data: b});
					end
					insBeq: begin
						writes = 1'b0;
						if (a == b) begin
							nextPc = pc + progImm[pc] / 4;
						end
					end
					default: begin
						val = 32'(pc * 4 + 4);
						nextPc = pc + progImm[pc] / 4;
					end
				endcase
				if (writes && progRd[pc] != '0) begin
					regs[progRd[pc]] = val;
					writeQ.push_back('{rd: progRd[pc], value: val});
				end
				pc = nextPc;
				steps++;
			end
		end
		if (!halted) begin
			failRun("reference model left the program without reaching the final jump");
		end
	endfunction

	function automatic void buildArithmetic();
		clearProgram();
		addIns(insAddi, 1, 0, 0, 5);
		addIns(insAddi, 2, 1, 0, 7);
		addIns(insAdd, 3, 2, 1, 0);
		addIns(insSub, 4, 3, 2, 0);
		addIns(insAnd, 5, 4, 3, 0);
		addIns(insOr, 6, 5, 4, 0);
		addIns(insAddi, 6, 6, 0, -3);
		addIns(insSub, 7, 0, 6, 0);
		addIns(insAdd, 7, 7, 5, 0);
		addIns(insJal, 0, 0, 0, 0);
	endfunction

	function automatic void buildLoadUse();
		clearProgram();
		addIns(insAddi, 1, 0, 0, 64);
		addIns(insAddi, 2, 0, 0, 'h123);
		addIns(insSw, 0, 1, 2, 0);
		addIns(insLw, 3, 1, 0, 0);
		addIns(insAdd, 4, 3, 3, 0);
		addIns(insLw, 5, 1, 0, 4);
		addIns(insAddi, 6, 5, 0, 1);
		addIns(insLw, 7, 1, 0, 8);
		// load feeding store data
		addIns(insSw, 0, 1, 7, 12);
		addIns(insAddi, 0, 1, 0, 9);
		addIns(insAdd, 0, 3, 3, 0);
		addIns(insLw, 0, 1, 0, 0);
		addIns(insLw, 1, 1, 0, 12);
		addIns(insAdd, 2, 1, 0, 0);
		addIns(insJal, 0, 0, 0, 0);
	endfunction

	function automatic void buildMemory();
		clearProgram();
		addIns(insAddi, 1, 0, 0, -4);
		addIns(insAddi, 2, 0, 0, 'h7ff);
		addIns(insSw, 0, 1, 2, 0);
		addIns(insAddi, 3, 0, 0, 256);
		addIns(insSw, 0, 3, 2, 4);
		addIns(insSw, 0, 3, 1, 8);
		addIns(insLw, 4, 3, 0, 4);
		addIns(insLw, 5, 3, 0, 8);
		addIns(insAdd, 6, 4, 5, 0);
		addIns(insSw, 0, 3, 6, 12);
		addIns(insLw, 7, 3, 0, 12);
		addIns(insLw, 8, 1, 0, 0);
		addIns(insOr, 9, 8, 7, 0);
		addIns(insSw, 0, 3, 9, -256);
		addIns(insLw, 10, 0, 0, 0);
		addIns(insLw, 11, 3, 0, 100);
		addIns(insJal, 0, 0, 0, 0);
	endfunction

	function automatic void buildBranches();
		clearProgram();
		addIns(insAddi, 1, 0, 0, 3);
		addIns(insAddi, 2, 0, 0, 3);
		// taken branch skips two
		addIns(insBeq, 0, 1, 2, 12);
		addIns(insAddi, 3, 0, 0, 1);
		addIns(insAddi, 4, 0, 0, 2);
		// not taken
		addIns(insBeq, 0, 1, 0, 8);
		addIns(insAddi, 5, 0, 0, 5);
		addIns(insJal, 6, 0, 0, 8);
		addIns(insSw, 0, 0, 1, 0);
		addIns(insAdd, 7, 6, 5, 0);
		addIns(insSw, 0, 0, 7, 8);
		addIns(insJal, 0, 0, 0, 0);
	endfunction

	function automatic void buildRandom();
		insKind_t  kind;
		int        span;
		int        imm;
		clearProgram();
		for (int i = 0; i < 200; i++) begin
			kind = insKind_t'($urandom_range(8, 0));
			span = (200 - i < 8) ? 200 - i : 8;
			case (kind)
				insBeq, insJal: imm = 4 * int'($urandom_range(span, 1));
				insLw, insSw:   imm = 4 * int'($urandom_range(63, 0)) - 128;
				default:        imm = int'($urandom_range(4095, 0)) - 2048;
			endcase
			// few registers for many hazards
			addIns(kind, int'($urandom_range(4, 0)), int'($urandom_range(4, 0)),
				int'($urandom_range(4, 0)), imm);
		end
		addIns(insJal, 0, 0, 0, 0);
	endfunction

	task automatic runProgram(input string name, input int cutAfter);
		int cycles;
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < 512; i++) begin
			imem[i[8:0]] = (i < progKind.size()) ? encode(i) : '0;
		end
		runReference();
		repeat (5) @(negedge clk);
		reset = 1'b0;
		checkValue("imemAddr", imemAddr, '0);
		cycles = 0;
		while ((writeQ.size() > 0 || storeQ.size() > 0) &&
			(cutAfter == 0 || cycles < cutAfter)) begin
			@(negedge clk);
			cycles++;
			if (idleCycles > pulseTimeout) begin
				failRun($sformatf("%s: no write or store seen for %0d cycles", name, pulseTimeout));
			end
			if (cycles > runTimeout) begin
				failRun($sformatf("%s: program did not finish in %0d cycles", name, runTimeout));
			end
		end
		// stray writes would show while the final jump spins
		if (cutAfter == 0) begin
			repeat (20) @(negedge clk);
		end
	endtask

	// memory models drive their data on the falling edge
	always @(negedge clk) begin
		imemData <= imem[imemAddr[10:2]];
		dmemRdata <= dmem[dmemAddr[9:2]];
	end

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i[7:0]] <= fillWord(i);
			end
		end else if (dmemWe === 1'b1) begin
			dmem[dmemAddr[9:2]] <= dmemWdata;
		end
	end

	// compare retire and store pulses against the model lists
	always @(posedge clk) begin
		if (reset) begin
			if (resetCycles > 0) begin
				checkValue("wbValid", 32'(wbValid), '0);
				checkValue("dmemWe", 32'(dmemWe), '0);
			end
			resetCycles++;
			idleCycles = 0;
		end else begin
			resetCycles = 0;
			idleCycles++;
			if (wbValid === 1'b1) begin
				if (writeQ.size() == 0) begin
					failRun("a register write retired when none was expected");
				end
				expWrite = writeQ.pop_front();
				checkValue("wbRd", 32'(wbRd), 32'(expWrite.rd));
				checkValue("wbData", wbData, expWrite.value);
				idleCycles = 0;
			end
			if (dmemWe === 1'b1) begin
				if (storeQ.size() == 0) begin
					failRun("a store reached data memory when none was expected");
				end
				expStore = storeQ.pop_front();
				checkValue("dmemAddr", dmemAddr, expStore.addr);
				checkValue("dmemWdata", dmemWdata, expStore.data);
				idleCycles = 0;
			end
		end
	end

	initial begin
		void'($urandom(31));
		buildArithmetic();
		runProgram("arithmetic chain", 0);
		buildLoadUse();
		runProgram("load-use", 0);
		buildMemory();
		runProgram("stores and loads", 0);
		buildBranches();
		runProgram("branches and jumps", 0);
		buildRandom();
		// reset lands while the random program is in flight
		runProgram("random program cut by reset", 40);
		runProgram("random program", 0);
		$display("TEST PASS");
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
isaPkg.sv
pipePkg.sv
hazardIf.sv
hazardUnit.sv
regFile.sv
pipeReg.sv
decoder.sv
execUnit.sv
pipelineCore.sv
tbCore.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tbCore
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
